//--- design/cpuPkg.sv
package cpuPkg;

    localparam int AddrWidth = 6;
    localparam int DataWidth = 16;
    localparam int FieldWidth = 4;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [DataWidth-1:0] wordT;
    typedef logic [2*DataWidth-1:0] instrT;   // First word high, immediate low

    typedef logic [FieldWidth-1:0] opcodeT;
    typedef logic [FieldWidth-1:0] fieldT;

    localparam opcodeT OpMov  = 4'd0;
    localparam opcodeT OpAdd  = 4'd1;
    localparam opcodeT OpSub  = 4'd2;
    localparam opcodeT OpMul  = 4'd3;
    localparam opcodeT OpIn   = 4'd7;
    localparam opcodeT OpOut  = 4'd8;
    localparam opcodeT OpStop = 4'd15;

    // Bit positions inside the first instruction word
    localparam int OpcodeLsb = 12;
    localparam int Op1Lsb = 8;
    localparam int Op2Lsb = 4;
    localparam int Op3Lsb = 0;
    localparam int ModeBit = 3;     // Indirect flag within a field

    localparam fieldT ImmField = 4'd8;    // MOV operand 3 marking the immediate form
    localparam addrT ResetPc = 6'd8;

    typedef enum logic [3:0] {
        Reset,
        Fetch0,
        Fetch1,
        Fetch2,
        Operand,
        Indirect,
        Execute,
        DestIndirect,
        WriteMem,
        Halt
    } cpuStateT;

    typedef enum logic [2:0] {MarPc, MarOp1, MarOp2, MarOp3, MarMem} marSelT;
    typedef enum logic [1:0] {AccMem, AccImm, AccIn, AccAlu} accSelT;
    typedef enum logic {MdrAcc, MdrAlu} mdrSelT;

endpackage

//--- design/cpuCtrlIf.sv
`timescale 1ns/100ps

interface cpuCtrlIf;

    logic ldPc;
    logic incPc;
    logic ldIrHigh;
    logic ldIrLow;
    logic ldMar;
    logic ldMdr;
    logic ldAcc;
    logic ldOut;

    cpuPkg::marSelT marSel;
    cpuPkg::accSelT accSel;
    cpuPkg::mdrSelT mdrSel;

    // Decoded instruction and PC back from the datapath
    cpuPkg::opcodeT opcode;
    cpuPkg::fieldT op1;
    cpuPkg::fieldT op2;
    cpuPkg::fieldT op3;
    cpuPkg::addrT pc;

    modport ctrl (
        output ldPc, incPc, ldIrHigh, ldIrLow, ldMar, ldMdr, ldAcc, ldOut,
        output marSel, accSel, mdrSel,
        input  opcode, op1, op2, op3
    );

    modport dp (
        input  ldPc, incPc, ldIrHigh, ldIrLow, ldMar, ldMdr, ldAcc, ldOut,
        input  marSel, accSel, mdrSel,
        output opcode, op1, op2, op3, pc
    );

endinterface

//--- design/cpuAlu.sv
`timescale 1ns/100ps

module cpuAlu (
    input  cpuPkg::opcodeT opcode,
    input  cpuPkg::wordT   a,
    input  cpuPkg::wordT   b,
    output cpuPkg::wordT   result
);

    always_comb begin
        case (opcode)
            cpuPkg::OpAdd: begin
                result = a + b;
            end
            cpuPkg::OpSub: begin
                result = a - b;
            end
            cpuPkg::OpMul: begin
                result = a * b;     // Low half of the product
            end
            default: begin
                // MOV uses this to forward the source word
                result = a;
            end
        endcase
    end

endmodule

//--- design/cpuDatapath.sv
`timescale 1ns/100ps

module cpuDatapath (
    input  logic         clk,
    input  logic         rst_n,
    cpuCtrlIf.dp         dp,
    input  cpuPkg::wordT memRData,
    input  cpuPkg::wordT inData,
    input  cpuPkg::wordT aluResult,
    output cpuPkg::wordT acc,
    output cpuPkg::addrT memAddr,
    output cpuPkg::wordT memWData,
    output cpuPkg::wordT out
);

    cpuPkg::addrT  pc;
    cpuPkg::instrT ir;
    cpuPkg::addrT  mar;
    cpuPkg::wordT  mdr;

    cpuPkg::wordT  irHigh;
    cpuPkg::addrT  marNext;
    cpuPkg::wordT  accNext;
    cpuPkg::wordT  mdrNext;

    // Decode sees the fetched word during its own load cycle
    assign irHigh = dp.ldIrHigh ? memRData : ir[cpuPkg::DataWidth +: cpuPkg::DataWidth];

    assign dp.opcode = irHigh[cpuPkg::OpcodeLsb +: cpuPkg::FieldWidth];
    assign dp.op1 = irHigh[cpuPkg::Op1Lsb +: cpuPkg::FieldWidth];
    assign dp.op2 = irHigh[cpuPkg::Op2Lsb +: cpuPkg::FieldWidth];
    assign dp.op3 = irHigh[cpuPkg::Op3Lsb +: cpuPkg::FieldWidth];
    assign dp.pc = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (dp.ldPc) begin
            pc <= cpuPkg::ResetPc;
        end else if (dp.incPc) begin
            pc <= pc + cpuPkg::addrT'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (dp.ldIrHigh) begin
            ir[cpuPkg::DataWidth +: cpuPkg::DataWidth] <= memRData;
        end
        if (dp.ldIrLow) begin
            ir[0 +: cpuPkg::DataWidth] <= memRData;   // Immediate word
        end
    end

    always_comb begin
        case (dp.marSel)
            cpuPkg::MarPc: begin
                marNext = pc;
            end
            cpuPkg::MarOp1: begin
                marNext = cpuPkg::addrT'(dp.op1[cpuPkg::ModeBit-1:0]);
            end
            cpuPkg::MarOp2: begin
                marNext = cpuPkg::addrT'(dp.op2[cpuPkg::ModeBit-1:0]);
            end
            cpuPkg::MarOp3: begin
                marNext = cpuPkg::addrT'(dp.op3[cpuPkg::ModeBit-1:0]);
            end
            default: begin
                marNext = memRData[cpuPkg::AddrWidth-1:0];  // Pointer word
            end
        endcase
    end

    always_comb begin
        case (dp.accSel)
            cpuPkg::AccMem: accNext = memRData;
            cpuPkg::AccImm: accNext = ir[0 +: cpuPkg::DataWidth];
            cpuPkg::AccIn:  accNext = inData;
            default:        accNext = aluResult;
        endcase
    end

    // MDR and out follow the accumulator's new value, not its old one
    assign mdrNext = (dp.mdrSel == cpuPkg::MdrAlu) ? aluResult : accNext;

    always_ff @(posedge clk) begin
        if (dp.ldMar) begin
            mar <= marNext;
        end
        if (dp.ldMdr) begin
            mdr <= mdrNext;
        end
        if (dp.ldAcc) begin
            acc <= accNext;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out <= '0;
        end else if (dp.ldOut) begin
            out <= accNext;
        end
    end

    assign memAddr = mar;
    assign memWData = mdr;

endmodule

//--- design/cpuController.sv
`timescale 1ns/100ps

module cpuController (
    input  logic   clk,
    input  logic   rst_n,
    cpuCtrlIf.ctrl ctrl,
    input  logic   control,
    output logic   memWe,
    output logic   halted
);

    cpuPkg::cpuStateT state;
    cpuPkg::cpuStateT stateNext;

    // Number of the operand field being fetched, 1 to 3
    logic [1:0] opIdx;
    logic [1:0] opIdxNext;

    cpuPkg::fieldT  curField;
    cpuPkg::marSelT opMarSel;
    logic           isArith;
    logic           isMovImm;
    logic           lastOp;
    logic           toDest;

    assign isArith = ctrl.opcode inside {cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpMul};
    assign isMovImm = (ctrl.opcode == cpuPkg::OpMov) && (ctrl.op3 == cpuPkg::ImmField);

    // Arithmetic reads operand 3 first, so operand 2 meets the ALU straight from memory
    assign lastOp = (opIdx != 2'd3);

    always_comb begin
        case (opIdx)
            2'd1: begin
                curField = ctrl.op1;
                opMarSel = cpuPkg::MarOp1;
            end
            2'd2: begin
                curField = ctrl.op2;
                opMarSel = cpuPkg::MarOp2;
            end
            default: begin
                curField = ctrl.op3;
                opMarSel = cpuPkg::MarOp3;
            end
        endcase
    end

    assign ctrl.ldIrHigh = (state == cpuPkg::Fetch1);
    assign memWe = (state == cpuPkg::WriteMem);
    assign halted = (state == cpuPkg::Halt);

    always_comb begin
        stateNext = state;
        opIdxNext = opIdx;
        toDest = 1'b0;
        ctrl.ldPc = 1'b0;
        ctrl.incPc = 1'b0;
        ctrl.ldIrLow = 1'b0;
        ctrl.ldMar = 1'b0;
        ctrl.ldMdr = 1'b0;
        ctrl.ldAcc = 1'b0;
        ctrl.ldOut = 1'b0;
        ctrl.marSel = cpuPkg::MarPc;
        ctrl.accSel = cpuPkg::AccAlu;
        ctrl.mdrSel = cpuPkg::MdrAlu;

        case (state)
            cpuPkg::Reset: begin
                ctrl.ldPc = 1'b1;
                stateNext = cpuPkg::Fetch0;
            end
            cpuPkg::Fetch0: begin
                ctrl.ldMar = 1'b1;
                ctrl.incPc = 1'b1;
                stateNext = cpuPkg::Fetch1;
            end
            cpuPkg::Fetch1: begin
                case (ctrl.opcode)
                    cpuPkg::OpMov: begin
                        if (isMovImm) begin
                            ctrl.ldMar = 1'b1;  // Point at the second word
                            ctrl.incPc = 1'b1;
                            stateNext = cpuPkg::Fetch2;
                        end else begin
                            opIdxNext = 2'd2;
                            stateNext = cpuPkg::Operand;
                        end
                    end
                    cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpMul: begin
                        opIdxNext = 2'd3;
                        stateNext = cpuPkg::Operand;
                    end
                    cpuPkg::OpOut: begin
                        opIdxNext = 2'd1;
                        stateNext = cpuPkg::Operand;
                    end
                    default: begin
                        stateNext = cpuPkg::Execute;
                    end
                endcase
            end
            cpuPkg::Fetch2: begin
                ctrl.ldIrLow = 1'b1;
                stateNext = cpuPkg::Execute;
            end
            cpuPkg::Operand: begin
                ctrl.marSel = opMarSel;
                ctrl.ldMar = 1'b1;
                if (isArith && opIdx == 2'd2) begin
                    ctrl.accSel = cpuPkg::AccMem;   // Operand 3 value
                    ctrl.ldAcc = 1'b1;
                end
                if (curField[cpuPkg::ModeBit]) begin
                    stateNext = cpuPkg::Indirect;
                end else if (lastOp) begin
                    stateNext = cpuPkg::Execute;
                end else begin
                    opIdxNext = 2'd2;
                end
            end
            cpuPkg::Indirect: begin
                ctrl.marSel = cpuPkg::MarMem;
                ctrl.ldMar = 1'b1;
                if (lastOp) begin
                    stateNext = cpuPkg::Execute;
                end else begin
                    opIdxNext = 2'd2;
                    stateNext = cpuPkg::Operand;
                end
            end
            cpuPkg::Execute: begin
                case (ctrl.opcode)
                    cpuPkg::OpMov: begin
                        ctrl.ldAcc = 1'b1;
                        ctrl.ldMdr = 1'b1;
                        toDest = 1'b1;
                        if (isMovImm) begin
                            ctrl.accSel = cpuPkg::AccImm;
                            ctrl.mdrSel = cpuPkg::MdrAcc;
                        end else begin
                            ctrl.accSel = cpuPkg::AccMem;
                            ctrl.mdrSel = cpuPkg::MdrAlu;   // ALU forwards the source
                        end
                    end
                    cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpMul: begin
                        ctrl.accSel = cpuPkg::AccAlu;
                        ctrl.ldAcc = 1'b1;
                        ctrl.mdrSel = cpuPkg::MdrAlu;
                        ctrl.ldMdr = 1'b1;
                        toDest = 1'b1;
                    end
                    cpuPkg::OpIn: begin
                        // Hold here until control goes high
                        if (control) begin
                            ctrl.accSel = cpuPkg::AccIn;
                            ctrl.ldAcc = 1'b1;
                            ctrl.mdrSel = cpuPkg::MdrAcc;
                            ctrl.ldMdr = 1'b1;
                            toDest = 1'b1;
                        end
                    end
                    cpuPkg::OpOut: begin
                        ctrl.accSel = cpuPkg::AccMem;
                        ctrl.ldAcc = 1'b1;
                        ctrl.ldOut = 1'b1;
                        stateNext = cpuPkg::Fetch0;
                    end
                    cpuPkg::OpStop: begin
                        stateNext = cpuPkg::Halt;
                    end
                    default: begin
                        stateNext = cpuPkg::Fetch0;     // Unused opcode, no-op
                    end
                endcase

                if (toDest) begin
                    ctrl.marSel = cpuPkg::MarOp1;
                    ctrl.ldMar = 1'b1;
                    if (ctrl.op1[cpuPkg::ModeBit]) begin
                        stateNext = cpuPkg::DestIndirect;
                    end else begin
                        stateNext = cpuPkg::WriteMem;
                    end
                end
            end
            cpuPkg::DestIndirect: begin
                ctrl.marSel = cpuPkg::MarMem;
                ctrl.ldMar = 1'b1;
                stateNext = cpuPkg::WriteMem;
            end
            cpuPkg::WriteMem: begin
                stateNext = cpuPkg::Fetch0;
            end
            cpuPkg::Halt: begin
                stateNext = cpuPkg::Halt;
            end
            default: begin
                stateNext = cpuPkg::Reset;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpuPkg::Reset;
            opIdx <= '0;
        end else begin
            state <= stateNext;
            opIdx <= opIdxNext;
        end
    end

endmodule

//--- design/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
    input  logic         clk,
    input  logic         rst_n,
    input  cpuPkg::wordT memRData,
    input  cpuPkg::wordT inData,
    input  logic         control,
    output cpuPkg::addrT memAddr,
    output cpuPkg::wordT memWData,
    output logic         memWe,
    output cpuPkg::wordT out,
    output cpuPkg::addrT pc,
    output logic         halted
);

    cpuCtrlIf ctrlIf ();

    cpuPkg::wordT acc;
    cpuPkg::wordT aluResult;

    cpuController controller_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrlIf.ctrl),
        .control (control),
        .memWe   (memWe),
        .halted  (halted)
    );

    cpuDatapath datapath_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dp        (ctrlIf.dp),
        .memRData  (memRData),
        .inData    (inData),
        .aluResult (aluResult),
        .acc       (acc),
        .memAddr   (memAddr),
        .memWData  (memWData),
        .out       (out)
    );

    // Operand 2 comes straight from memory, operand 3 waits in the accumulator
    cpuAlu alu_i (
        .opcode (ctrlIf.opcode),
        .a      (memRData),
        .b      (acc),
        .result (aluResult)
    );

    assign pc = ctrlIf.pc;

endmodule

//--- bench/cpuProperties.sv
`timescale 1ns/100ps

module cpuProperties (
    input logic         clk,
    input logic         rst_n,
    input logic         memWe,
    input logic         halted,
    input cpuPkg::addrT pc
);

    int assertFails = 0;    // Failed assertion count

    singleWrite: assert property (@(posedge clk) disable iff (!rst_n) memWe |=> !memWe)
        else begin
            assertFails++;
            $error("memWe stayed high for two cycles");
        end

    // A halted processor stays halted and must not touch memory
    noWriteHalted: assert property (@(posedge clk) disable iff (!rst_n)
                                    halted |=> halted && !memWe)
        else begin
            assertFails++;
            $error("memWe high or halted dropped after halt");
        end

    pcFrozen: assert property (@(posedge clk) disable iff (!rst_n) halted |=> $stable(pc))
        else begin
            assertFails++;
            $error("pc moved while halted");
        end

endmodule

bind cpuTop cpuProperties properties_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .memWe  (memWe),
    .halted (halted),
    .pc     (pc)
);

//--- bench/isaModel.svh
cpuPkg::wordT modelMem [64];
cpuPkg::wordT modelOuts [$];   // OUT values without repeats of the previous one
cpuPkg::addrT modelPc;         // Word after STOP

function automatic cpuPkg::addrT effAddr(input cpuPkg::fieldT f);
    if (f[cpuPkg::ModeBit]) begin
        return cpuPkg::addrT'(modelMem[f[cpuPkg::ModeBit-1:0]]);   // Through pointer word
    end
    return cpuPkg::addrT'(f[cpuPkg::ModeBit-1:0]);
endfunction

task automatic runIsaModel();
    cpuPkg::addrT   mpc;
    cpuPkg::wordT   w;
    cpuPkg::wordT   prevOut;
    cpuPkg::opcodeT op;
    cpuPkg::fieldT  f1;
    cpuPkg::fieldT  f2;
    cpuPkg::fieldT  f3;
    int             inPos;
    bit             running;

    for (int a = 0; a < 64; a++) begin
        modelMem[a] = mem[a];
    end
    modelOuts.delete();
    mpc = cpuPkg::ResetPc;
    prevOut = '0;
    inPos = 0;
    running = 1'b1;
    while (running) begin
        w = modelMem[mpc];
        mpc = mpc + cpuPkg::addrT'(1);
        op = w[15:12];
        f1 = w[11:8];
        f2 = w[7:4];
        f3 = w[3:0];
        case (op)
            cpuPkg::OpMov: begin
                if (f3 == cpuPkg::ImmField) begin
                    modelMem[effAddr(f1)] = modelMem[mpc];
                    mpc = mpc + cpuPkg::addrT'(1);
                end else begin
                    modelMem[effAddr(f1)] = modelMem[effAddr(f2)];
                end
            end
            cpuPkg::OpAdd: modelMem[effAddr(f1)] = modelMem[effAddr(f2)] + modelMem[effAddr(f3)];
            cpuPkg::OpSub: modelMem[effAddr(f1)] = modelMem[effAddr(f2)] - modelMem[effAddr(f3)];
            cpuPkg::OpMul: modelMem[effAddr(f1)] = modelMem[effAddr(f2)] * modelMem[effAddr(f3)];
            cpuPkg::OpIn: begin
                modelMem[effAddr(f1)] = inValues[inPos];
                inPos++;
            end
            cpuPkg::OpOut: begin
                w = modelMem[effAddr(f1)];
                if (w != prevOut) begin
                    modelOuts.push_back(w);
                    prevOut = w;
                end
            end
            cpuPkg::OpStop: running = 1'b0;
            default: begin
                // Unused opcodes fall through as no-ops
            end
        endcase
    end
    modelPc = mpc;
endtask

//--- bench/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

    localparam int NumPrograms = 8;
    localparam int ProgLength = 12;
    localparam int CycleLimit = NumPrograms * (ProgLength + 1) * 14 + 100;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         control;
    cpuPkg::wordT inData;
    cpuPkg::wordT memRData;
    cpuPkg::addrT memAddr;
    cpuPkg::wordT memWData;
    logic         memWe;
    cpuPkg::wordT out;
    cpuPkg::addrT pc;
    logic         halted;

    cpuPkg::wordT mem [64];
    logic         isInAddr [64];    // Addresses holding an IN instruction
    cpuPkg::wordT inValues [$];
    cpuPkg::wordT outSeen [$];
    cpuPkg::wordT lastOut;
    logic [31:0]  lfsr;
    int           inPhase;
    int           holdCnt;
    int           inIdx;
    int           cycleCount = 0;
    int           testErrors;
    int           errorCount = 0;
    int           passCount = 0;
    int           failCount = 0;
    string        testName;

    `include "isaModel.svh"

    cpuTop dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .memRData (memRData),
        .inData   (inData),
        .control  (control),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memWe    (memWe),
        .out      (out),
        .pc       (pc),
        .halted   (halted)
    );

    always #5 clk = ~clk;

    assign memRData = mem[memAddr];
    always @(posedge clk) begin
        if (memWe) begin
            mem[memAddr] <= memWData;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] nextBits(input int count);
        logic [31:0] value;
        logic        fb;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic cpuPkg::fieldT srcField();
        if (nextBits(1) == 1) begin
            return {2'b11, 1'b1, 1'(nextBits(1))};  // Pointer word 6 or 7
        end
        return {1'b0, 3'(nextBits(3))};
    endfunction

    function automatic cpuPkg::fieldT dstField();
        if (nextBits(1) == 1) begin
            return {2'b11, 1'b1, 1'(nextBits(1))};
        end
        return {1'b0, 3'(nextBits(3) % 6)};
    endfunction

    task automatic buildProgram();
        int            a;
        int            wa;
        int            kind;
        cpuPkg::fieldT f1;
        cpuPkg::fieldT f2;
        cpuPkg::fieldT f3;
        for (a = 0; a < 64; a++) begin
            mem[a] = {4'hF, 6'd0, 6'(a)};   // STOP with the address below it
            isInAddr[a] = 1'b0;
        end
        inValues.delete();
        for (a = 0; a < 6; a++) begin
            mem[a] = 16'(nextBits(16));
        end
        mem[6] = 16'(nextBits(3) % 6);
        mem[7] = 16'(nextBits(3) % 6);
        wa = cpuPkg::ResetPc;
        for (a = 0; a < ProgLength; a++) begin
            kind = nextBits(3) % 7;
            f1 = dstField();
            f2 = srcField();
            f3 = srcField();
            case (kind)
                0: mem[wa] = {cpuPkg::OpMov, f1, f2, 4'd0};
                1: begin
                    mem[wa] = {cpuPkg::OpMov, f1, 4'd0, cpuPkg::ImmField};
                    wa++;
                    mem[wa] = 16'(nextBits(16));
                end
                2: mem[wa] = {cpuPkg::OpAdd, f1, f2, f3};
                3: mem[wa] = {cpuPkg::OpSub, f1, f2, f3};
                4: mem[wa] = {cpuPkg::OpMul, f1, f2, f3};
                5: begin
                    mem[wa] = {cpuPkg::OpIn, f1, 8'h00};
                    isInAddr[wa] = 1'b1;
                    inValues.push_back(16'(nextBits(16)));
                end
                default: mem[wa] = {cpuPkg::OpOut, f2, 8'h00};
            endcase
            wa++;
        end
        mem[wa] = {cpuPkg::OpStop, 12'h000};
    endtask

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error in %s, %s: expected 0x%0h, actual 0x%0h",
                     testName, what, expected, actual);
            testErrors++;
            errorCount++;
        end
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("%s: %s, %0d out values, %0d IN values", testName,
                 (testErrors == 0) ? "pass" : "fail", outSeen.size(), inValues.size());
    endtask

    // Drives the IN handshake once the bus shows an IN word at pc - 1
    always @(posedge clk) begin
        if (!rst_n) begin
            inPhase = 0;
            inIdx = 0;
            control <= 1'b0;
        end else begin
            if (inPhase == 0 && isInAddr[memAddr] && pc == cpuPkg::addrT'(memAddr + 1)) begin
                holdCnt = 1 + nextBits(2);
                inPhase = 1;
            end
            if (inPhase == 1) begin
                if (holdCnt > 0) begin
                    control <= 1'b0;
                    inData <= 16'(nextBits(16));    // Noise that must not be taken
                    holdCnt--;
                end else begin
                    control <= 1'b1;
                    inData <= inValues[inIdx];
                    inIdx++;
                    inPhase = 2;
                end
            end else if (inPhase == 2) begin
                control <= 1'b0;
                inData <= 16'(nextBits(16));
                inPhase = 0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            outSeen.delete();
            lastOut = '0;
        end else if (out !== lastOut) begin
            outSeen.push_back(out);
            lastOut = out;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("Timeout: the processor did not halt within %0d cycles", CycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        control = 1'b0;
        inData = '0;
        lfsr = 32'hba29_2b88;
        for (int p = 0; p < NumPrograms; p++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            @(posedge clk);
            buildProgram();
            runIsaModel();
            @(posedge clk);
            rst_n <= 1'b1;
            testName = $sformatf("program %0d", p);
            testErrors = 0;
            @(posedge clk);
            while (halted !== 1'b1) begin
                @(posedge clk);
            end
            compareValue("pc at halt", modelPc, pc);
            repeat (3) @(posedge clk);
            compareValue("pc after halt", modelPc, pc);
            for (int a = 0; a < 64; a++) begin
                compareValue($sformatf("mem[%0d]", a), modelMem[a], mem[a]);
            end
            compareValue("out count", modelOuts.size(), outSeen.size());
            for (int i = 0; i < modelOuts.size() && i < outSeen.size(); i++) begin
                compareValue($sformatf("out value %0d", i), modelOuts[i], outSeen[i]);
            end
            finishTest();
        end
        testName = "assertions";
        testErrors = 0;
        compareValue("assertion failures", 0, dut_i.properties_i.assertFails);
        finishTest();
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+bench
design/cpuPkg.sv
design/cpuCtrlIf.sv
design/cpuAlu.sv
design/cpuDatapath.sv
design/cpuController.sv
design/cpuTop.sv
bench/cpuProperties.sv
bench/cpuTb.sv

//--- Bender.yml
package:
  name: accumulator_cpu

sources:
  - files:
      - design/cpuPkg.sv
      - design/cpuCtrlIf.sv
      - design/cpuAlu.sv
      - design/cpuDatapath.sv
      - design/cpuController.sv
      - design/cpuTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/cpuProperties.sv
      - bench/cpuTb.sv
